//--- logic/cms_pkg.sv
// ####################################################################
// continuous monitor shared definitions
// widths, control register map, WFI encoding and trace packet layout
// ####################################################################

package cms_pkg;

    localparam int xlen            = 32;
    localparam int instr_width     = 32;
    localparam int delta_width     = 32;
    localparam int ctrl_data_width = 32;
    localparam int pkt_width       = instr_width + delta_width + xlen;

    // wait-for-interrupt, closes a stream frame
    localparam logic [instr_width-1:0] wfi_instr = 32'h10500073;

    // control register map, other codes are ignored
    typedef enum logic [3:0] {
        start_addr_en = 4'd0,
        end_addr_en   = 4'd1,
        start_addr    = 4'd2,
        end_addr      = 4'd3,
        range_lo_en   = 4'd4,
        range_hi_en   = 4'd5,
        range_lo      = 4'd6,
        range_hi      = 4'd7
    } ctrl_addr_e;

    // field view of one packet, instr in the top bits
    typedef struct packed {
        logic [instr_width-1:0] instr;
        logic [delta_width-1:0] delta;
        logic [xlen-1:0]        pc;
    } trace_fields_t;

    // built as fields, stored and sent as a flat word
    typedef union packed {
        trace_fields_t        fields;
        logic [pkt_width-1:0] raw;
    } trace_pkt_u;

endpackage

//--- logic/ctrl_regs.sv
// ####################################################################
// control register file
// decodes address/data writes into trace trigger and range settings
// ####################################################################

`timescale 1ns/1ps

module ctrl_regs
    import cms_pkg::*;
#(
    // 1 = write on rising edge of the enable, 0 = write every enabled cycle
    parameter bit write_on_edge = 1'b1
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ctrl_addr_e                 ctrl_addr,
    input  logic [ctrl_data_width-1:0] ctrl_wdata,
    input  logic                       ctrl_write_enable,
    output logic                       cfg_write,
    output logic                       start_en,
    output logic                       end_en,
    output logic                       range_lo_en,
    output logic                       range_hi_en,
    output logic [xlen-1:0]            start_addr,
    output logic [xlen-1:0]            end_addr,
    output logic [xlen-1:0]            range_lo,
    output logic [xlen-1:0]            range_hi
);

    logic we_q;

    // previous enable for rising edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ctrl_write_enable;
        end
    end

    assign cfg_write = write_on_edge ? (ctrl_write_enable & ~we_q) : ctrl_write_enable;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_en    <= 1'b0;
            end_en      <= 1'b0;
            range_lo_en <= 1'b0;
            range_hi_en <= 1'b0;
            start_addr  <= '0;
            end_addr    <= '1;
            range_lo    <= '0;
            range_hi    <= '1;
        end else if (cfg_write) begin
            // labels are scoped, the ports share the register names
            case (ctrl_addr)
                cms_pkg::start_addr_en: begin
                    start_en <= ctrl_wdata[0];
                end
                cms_pkg::end_addr_en: begin
                    end_en <= ctrl_wdata[0];
                end
                cms_pkg::start_addr: begin
                    start_addr <= ctrl_wdata;
                end
                cms_pkg::end_addr: begin
                    end_addr <= ctrl_wdata;
                end
                cms_pkg::range_lo_en: begin
                    range_lo_en <= ctrl_wdata[0];
                end
                cms_pkg::range_hi_en: begin
                    range_hi_en <= ctrl_wdata[0];
                end
                cms_pkg::range_lo: begin
                    range_lo <= ctrl_wdata;
                end
                cms_pkg::range_hi: begin
                    range_hi <= ctrl_wdata;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- logic/trace_capture.sv
// ####################################################################
// trace capture
// two-stage PC/instruction history, new instruction detection and
// clock delta timestamping of recorded packets
// ####################################################################

`timescale 1ns/1ps

module trace_capture
    import cms_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [xlen-1:0]        pc,
    input  logic [instr_width-1:0] instr,
    input  logic                   record,
    output logic                   new_instr,
    output logic [xlen-1:0]        prev_pc,
    output trace_pkt_u             pkt
);

    logic [xlen-1:0]        pc_s0;
    logic [xlen-1:0]        pc_s1;
    logic [instr_width-1:0] instr_s0;
    logic [instr_width-1:0] instr_s1;
    logic [delta_width-1:0] cycle_cnt;
    logic [delta_width-1:0] last_ts;

    // two-stage pc history
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_s0 <= '0;
            pc_s1 <= '0;
        end else begin
            pc_s0 <= pc;
            pc_s1 <= pc_s0;
        end
    end

    always_ff @(posedge clk) begin
        instr_s0 <= instr;
        instr_s1 <= instr_s0;
    end

    // free-running counter and timestamp of the last recorded packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            last_ts   <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (record) begin
                last_ts <= cycle_cnt;
            end
        end
    end

    // stage 1 ends its run when stage 0 moves on
    assign new_instr = (pc_s0 != pc_s1) && (pc_s1 != '0);
    assign prev_pc   = pc_s1;

    always_comb begin
        pkt.fields.instr = instr_s1;
        pkt.fields.delta = cycle_cnt - last_ts;
        pkt.fields.pc    = pc_s1;
    end

    // record strobe only lands on a new non-zero instruction
    a_no_zero_pc: assert property (@(posedge clk) disable iff (!rst_n)
        record |-> new_instr && (prev_pc != '0));

endmodule

//--- logic/trace_qualifier.sv
// ####################################################################
// trace qualifier
// start/end trigger window and address range check, gives the
// one-cycle record strobe
// ####################################################################

`timescale 1ns/1ps

module trace_qualifier
    import cms_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] prev_pc,
    input  logic            new_instr,
    input  logic            cfg_write,
    input  logic            start_en,
    input  logic            end_en,
    input  logic [xlen-1:0] start_addr,
    input  logic [xlen-1:0] end_addr,
    input  logic            range_lo_en,
    input  logic            range_hi_en,
    input  logic [xlen-1:0] range_lo,
    input  logic [xlen-1:0] range_hi,
    output logic            record
);

    logic started;
    logic ended;
    logic in_window;
    logic in_range;

    // triggers match the live pc, not the history
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
            ended   <= 1'b0;
        end else if (!cfg_write) begin
            if (start_en && (pc == start_addr)) begin
                started <= 1'b1;
                ended   <= 1'b0;
            end
            // end wins when both addresses match the same pc
            if (end_en && (pc == end_addr)) begin
                ended   <= 1'b1;
                started <= 1'b0;
            end
        end
    end

    // disabled trigger leaves its side of the window open
    assign in_window = (started || !start_en) && (!ended || !end_en);

    // inclusive bounds
    assign in_range = ((prev_pc >= range_lo) || !range_lo_en) &&
                      ((prev_pc <= range_hi) || !range_hi_en);

    assign record = en && new_instr && in_window && in_range;

    a_trig_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(started && ended));

endmodule

//--- logic/trace_stream_out.sv
// ####################################################################
// trace stream output
// packet FIFO drained by an AXI-Stream master, tlast on WFI or
// every tlast_interval packets
// ####################################################################

`timescale 1ns/1ps

module trace_stream_out
    import cms_pkg::*;
#(
    // power of two, at least 2
    parameter int fifo_depth = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 record,
    input  trace_pkt_u           pkt,
    input  logic [31:0]          tlast_interval,
    input  logic                 tready,
    output logic                 tvalid,
    output logic [pkt_width-1:0] tdata,
    output logic                 tlast
);

    localparam int ptr_w = $clog2(fifo_depth);

    logic [pkt_width-1:0] mem_data [fifo_depth];
    logic                 mem_last [fifo_depth];
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [ptr_w:0]       count;
    logic [31:0]          int_cnt;
    logic                 full;
    logic                 push;
    logic                 pop;
    logic                 is_wfi;
    logic                 int_hit;
    logic                 last_in;

    assign full   = (count == fifo_depth[ptr_w:0]);
    assign tvalid = (count != '0);
    assign push   = record && !full;
    assign pop    = tvalid && tready;

    // tlast is fixed when the packet is queued
    assign is_wfi  = (pkt.fields.instr == wfi_instr);
    assign int_hit = (tlast_interval != '0) && ((int_cnt + 32'd1) == tlast_interval);
    assign last_in = is_wfi || int_hit;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= pkt.raw;
            mem_last[wr_ptr] <= last_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            int_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                // any tlast restarts the interval count
                int_cnt <= last_in ? 32'd0 : int_cnt + 32'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry drives the stream, gated so idle beats show zero
    assign tdata = tvalid ? mem_data[rd_ptr] : '0;
    assign tlast = tvalid && mem_last[rd_ptr];

    // a record into a full buffer is lost
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        record |-> !full);

    a_hold_stall: assert property (@(posedge clk) disable iff (!rst_n)
        tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast));

endmodule

//--- logic/continuous_monitor.sv
// ####################################################################
// continuous trace monitor, top level
// samples pc/instr, filters new instructions and streams packets out
// ####################################################################

`timescale 1ns/1ps

module continuous_monitor
    import cms_pkg::*;
#(
    parameter bit write_on_edge = 1'b1,
    parameter int fifo_depth    = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [xlen-1:0]            pc,
    input  logic [instr_width-1:0]     instr,
    input  logic                       en,
    input  ctrl_addr_e                 ctrl_addr,
    input  logic [ctrl_data_width-1:0] ctrl_wdata,
    input  logic                       ctrl_write_enable,
    input  logic [31:0]                tlast_interval,
    input  logic                       tready,
    output logic                       tvalid,
    output logic [pkt_width-1:0]       tdata,
    output logic                       tlast
);

    logic            cfg_write;
    logic            start_en;
    logic            end_en;
    logic            range_lo_en;
    logic            range_hi_en;
    logic [xlen-1:0] start_addr;
    logic [xlen-1:0] end_addr;
    logic [xlen-1:0] range_lo;
    logic [xlen-1:0] range_hi;
    logic            new_instr;
    logic [xlen-1:0] prev_pc;
    logic            record;
    trace_pkt_u      pkt;

    ctrl_regs #(
        .write_on_edge(write_on_edge)
    ) u_ctrl_regs (
        .clk(clk), .rst_n(rst_n),
        .ctrl_addr(ctrl_addr), .ctrl_wdata(ctrl_wdata),
        .ctrl_write_enable(ctrl_write_enable), .cfg_write(cfg_write),
        .start_en(start_en), .end_en(end_en),
        .range_lo_en(range_lo_en), .range_hi_en(range_hi_en),
        .start_addr(start_addr), .end_addr(end_addr),
        .range_lo(range_lo), .range_hi(range_hi)
    );

    trace_capture u_trace_capture (
        .clk(clk), .rst_n(rst_n), .pc(pc), .instr(instr), .record(record),
        .new_instr(new_instr), .prev_pc(prev_pc), .pkt(pkt)
    );

    trace_qualifier u_trace_qualifier (
        .clk(clk), .rst_n(rst_n), .en(en), .pc(pc), .prev_pc(prev_pc),
        .new_instr(new_instr), .cfg_write(cfg_write),
        .start_en(start_en), .end_en(end_en),
        .start_addr(start_addr), .end_addr(end_addr),
        .range_lo_en(range_lo_en), .range_hi_en(range_hi_en),
        .range_lo(range_lo), .range_hi(range_hi), .record(record)
    );

    trace_stream_out #(
        .fifo_depth(fifo_depth)
    ) u_trace_stream_out (
        .clk(clk), .rst_n(rst_n), .record(record), .pkt(pkt),
        .tlast_interval(tlast_interval), .tready(tready),
        .tvalid(tvalid), .tdata(tdata), .tlast(tlast)
    );

endmodule

//--- tests/tb_tasks.svh
// ####################################################################
// directed tests for the continuous monitor
// stimulus helpers, reference model of the recording rules, checker
// ####################################################################

// expected copies of the control registers and trigger flags
logic            cfg_start_en = 1'b0;
logic            cfg_end_en   = 1'b0;
logic            cfg_lo_en    = 1'b0;
logic            cfg_hi_en    = 1'b0;
logic [xlen-1:0] cfg_start    = '0;
logic [xlen-1:0] cfg_end      = '1;
logic [xlen-1:0] cfg_lo       = '0;
logic [xlen-1:0] cfg_hi       = '1;
logic            trig_started = 1'b0;
logic            trig_ended   = 1'b0;
int              since_last   = 0;

logic [xlen-1:0]        seq_pc[$];
logic [instr_width-1:0] seq_instr[$];
int                     seq_hold[$];
trace_pkt_u             exp_pkt[$];
logic                   exp_delta_chk[$];
logic                   exp_last[$];

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

// extra cycles keep the enable high with late_data on the bus
task automatic write_ctrl(input ctrl_addr_e addr, input logic [31:0] data,
                          input int extra = 0, input logic [31:0] late_data = '0);
    ctrl_addr         = addr;
    ctrl_wdata        = data;
    ctrl_write_enable = 1'b1;
    next_cycle();
    ctrl_wdata = late_data;
    repeat (extra) next_cycle();
    ctrl_write_enable = 1'b0;
    next_cycle();
    case (addr)
        start_addr_en: cfg_start_en = data[0];
        end_addr_en:   cfg_end_en = data[0];
        start_addr:    cfg_start = data;
        end_addr:      cfg_end = data;
        range_lo_en:   cfg_lo_en = data[0];
        range_hi_en:   cfg_hi_en = data[0];
        range_lo:      cfg_lo = data;
        range_hi:      cfg_hi = data;
        default: ;
    endcase
endtask

function automatic void add_ramp(input logic [xlen-1:0] base, input int n, input int hold);
    for (int i = 0; i < n; i++) begin
        seq_pc.push_back(base + 4 * i);
        seq_instr.push_back({base[19:0] + 20'(4 * i), 12'h013});
        seq_hold.push_back(hold);
    end
endfunction

function automatic void update_triggers(input logic [xlen-1:0] p);
    if (cfg_start_en && p == cfg_start) begin
        trig_started = 1'b1;
        trig_ended   = 1'b0;
    end
    if (cfg_end_en && p == cfg_end) begin
        trig_ended   = 1'b1;
        trig_started = 1'b0;
    end
endfunction

// an instruction is recorded as the next pc arrives, the triggers
// have seen that next pc by then
function automatic void build_expected();
    logic [xlen-1:0] nxt;
    trace_pkt_u      p;
    logic            last;
    logic            seen;
    int              gap;
    gap  = 0;
    seen = 1'b0;
    update_triggers(seq_pc[0]);
    foreach (seq_pc[i]) begin
        nxt = (i + 1 < seq_pc.size()) ? seq_pc[i + 1] : '0;
        update_triggers(nxt);
        gap += seq_hold[i];
        if (en && (trig_started || !cfg_start_en) && (!trig_ended || !cfg_end_en) &&
            (seq_pc[i] >= cfg_lo || !cfg_lo_en) && (seq_pc[i] <= cfg_hi || !cfg_hi_en)) begin
            p.fields.pc    = seq_pc[i];
            p.fields.instr = seq_instr[i];
            p.fields.delta = gap;
            last = (seq_instr[i] == wfi_instr) ||
                   (tlast_interval != 0 && since_last + 1 == tlast_interval);
            since_last = last ? 0 : since_last + 1;
            exp_pkt.push_back(p);
            exp_delta_chk.push_back(seen);
            exp_last.push_back(last);
            seen = 1'b1;
            gap  = 0;
        end
    end
endfunction

task automatic run_and_check(input string name);
    trace_pkt_u got;
    trace_pkt_u want;
    int         guard;
    build_expected();
    foreach (seq_pc[i]) begin
        pc    = seq_pc[i];
        instr = seq_instr[i];
        repeat (seq_hold[i]) next_cycle();
    end
    // back to zero so the last instruction leaves stage 1
    pc    = '0;
    instr = '0;
    repeat (4) next_cycle();
    guard = 0;
    while (tvalid && guard < 64) begin
        next_cycle();
        guard++;
    end
    if (tvalid) begin
        error_count++;
        $display("%s: stream still holds packets after %0d cycles", name, guard);
    end
    check_count++;
    assert (rx_pkt.size() == exp_pkt.size()) else begin
        error_count++;
        $display("ERROR %s: packet count expected %0d actual %0d",
                 name, exp_pkt.size(), rx_pkt.size());
    end
    foreach (exp_pkt[k]) begin
        if (k < rx_pkt.size()) begin
            got  = rx_pkt[k];
            want = exp_pkt[k];
            // first delta of a run depends on earlier tests
            if (!exp_delta_chk[k]) begin
                want.fields.delta = got.fields.delta;
            end
            check_count++;
            assert ({exp_last[k], want.raw} == {rx_last[k], got.raw}) else begin
                error_count++;
                $display("ERROR %s: packet %0d expected last=%0b %h actual last=%0b %h",
                         name, k, exp_last[k], want.raw, rx_last[k], got.raw);
            end
        end
    end
    rx_pkt.delete();
    rx_last.delete();
    exp_pkt.delete();
    exp_delta_chk.delete();
    exp_last.delete();
    seq_pc.delete();
    seq_instr.delete();
    seq_hold.delete();
endtask

task automatic test_basic();
    add_ramp(32'h1000, 8, 4);
    run_and_check("basic");
endtask

task automatic test_triggers();
    // enable held two more cycles over a wrong start address
    write_ctrl(start_addr, 32'h108, 2, 32'h100);
    write_ctrl(end_addr, 32'h114);
    write_ctrl(start_addr_en, 32'd1);
    write_ctrl(end_addr_en, 32'd1);
    add_ramp(32'h100, 8, 3);
    run_and_check("triggers");
    write_ctrl(start_addr_en, 32'd0);
    write_ctrl(end_addr_en, 32'd0);
endtask

task automatic test_range();
    write_ctrl(range_lo, 32'h208);
    write_ctrl(range_hi, 32'h214);
    write_ctrl(range_lo_en, 32'd1);
    write_ctrl(range_hi_en, 32'd1);
    add_ramp(32'h200, 8, 2);
    run_and_check("range");
    write_ctrl(range_hi_en, 32'd0);
    add_ramp(32'h200, 8, 2);
    run_and_check("range_open_hi");
    write_ctrl(range_lo_en, 32'd0);
endtask

task automatic test_tlast();
    tlast_interval = 32'd3;
    add_ramp(32'h300, 10, 2);
    // wfi first clears the count left from earlier tests
    seq_instr[0] = wfi_instr;
    seq_instr[5] = wfi_instr;
    run_and_check("tlast");
    tlast_interval = '0;
endtask

task automatic test_backpressure();
    rand_ready = 1'b1;
    add_ramp(32'h400, 6, 4);
    run_and_check("backpressure");
    en = 1'b0;
    add_ramp(32'h500, 6, 4);
    run_and_check("disabled");
    en         = 1'b1;
    rand_ready = 1'b0;
endtask

//--- tests/tb_continuous_monitor.sv
// ####################################################################
// continuous monitor testbench
// directed tests with a stream sink and a run length limit
// ####################################################################

`timescale 1ns/1ps

module tb_continuous_monitor
    import cms_pkg::*;
();

    // run limit is twice the summed rough test lengths in cycles
    localparam int basic_len   = 50;
    localparam int trigger_len = 60;
    localparam int range_len   = 70;
    localparam int tlast_len   = 40;
    localparam int bp_len      = 90;
    localparam int max_cycles  = 2 * (basic_len + trigger_len + range_len + tlast_len + bp_len);

    logic                       clk;
    logic                       rst_n;
    logic [xlen-1:0]            pc;
    logic [instr_width-1:0]     instr;
    logic                       en;
    ctrl_addr_e                 ctrl_addr;
    logic [ctrl_data_width-1:0] ctrl_wdata;
    logic                       ctrl_write_enable;
    logic [31:0]                tlast_interval;
    logic                       tready;
    logic                       tvalid;
    logic [pkt_width-1:0]       tdata;
    logic                       tlast;

    logic        rand_ready;
    logic        ready_next;
    logic [31:0] rng_state;
    int          cycle_cnt;
    int          error_count;
    int          check_count;
    trace_pkt_u  beat;
    trace_pkt_u  rx_pkt[$];
    logic        rx_last[$];

    `include "tb_tasks.svh"

    initial clk = 1'b0;
    always #5 clk = ~clk;

    continuous_monitor #(
        .write_on_edge(1'b1),
        .fifo_depth(8)
    ) u_dut (
        .clk(clk), .rst_n(rst_n), .pc(pc), .instr(instr), .en(en),
        .ctrl_addr(ctrl_addr), .ctrl_wdata(ctrl_wdata),
        .ctrl_write_enable(ctrl_write_enable), .tlast_interval(tlast_interval),
        .tready(tready), .tvalid(tvalid), .tdata(tdata), .tlast(tlast)
    );

    // stream sink takes one beat per handshake
    always @(posedge clk) begin
        if (rst_n && tvalid && tready) begin
            beat.raw = tdata;
            rx_pkt.push_back(beat);
            rx_last.push_back(tlast);
        end
    end

    // ready mode is picked at the edge and applied just after it
    always @(posedge clk) begin
        ready_next = 1'b1;
        if (rand_ready) begin
            rng_state  = xorshift32(rng_state);
            ready_next = rng_state[0];
        end
        #1;
        tready = ready_next;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("run stopped, tests did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst_n             = 1'b0;
        pc                = '0;
        instr             = '0;
        en                = 1'b1;
        ctrl_addr         = start_addr_en;
        ctrl_wdata        = '0;
        ctrl_write_enable = 1'b0;
        tlast_interval    = '0;
        tready            = 1'b1;
        rand_ready        = 1'b0;
        rng_state         = 32'h1a42;
        cycle_cnt         = 0;
        error_count       = 0;
        check_count       = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        test_basic();
        test_triggers();
        test_range();
        test_tlast();
        test_backpressure();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
logic/cms_pkg.sv
logic/ctrl_regs.sv
logic/trace_capture.sv
logic/trace_qualifier.sv
logic/trace_stream_out.sv
logic/continuous_monitor.sv
tests/tb_continuous_monitor.sv

//--- Bender.yml
package:
  name: continuous_monitor

sources:
  - files:
      - logic/cms_pkg.sv
      - logic/ctrl_regs.sv
      - logic/trace_capture.sv
      - logic/trace_qualifier.sv
      - logic/trace_stream_out.sv
      - logic/continuous_monitor.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_continuous_monitor.sv
